// File: Makefile
VERILATOR ?= verilator
TOP       ?= evr_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/evr_tb.sv
`timescale 1ns/1ns
`default_nettype none

module evr_tb import evr_pkg::*; ();
    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_MARGIN = 1000;
    localparam int EXTRA_EVENTS    = 3;

    // One table row: received word and what it should cause
    typedef struct packed {
        rx_word_t  word;
        logic      exp_ev;
        byte_t     exp_code;
        logic      exp_wr;
        buf_addr_t wr_addr;
        word_t     wr_data;
        logic      exp_err;
    } row_t;

    logic     rx_clk;
    logic     app_rst;
    rx_word_t rx_word_i;
    logic     ev_credit_i;
    mmr_req_t mmr_req_i;
    logic     ev_valid_o;
    byte_t    ev_code_o;
    mmr_rsp_t mmr_rsp_o;

    row_t     rows[$];
    byte_t    exp_codes[$];
    word_t    exp_buf [BUF_DEPTH];
    bit       exp_buf_set [BUF_DEPTH];
    rx_word_t rx_idle;
    byte_t    exp_code;
    logic     model_link = 1'b0;
    logic     model_ena = 1'b0;
    logic     run_err = 1'b0;
    logic     rows_ready = 1'b0;
    logic     credits_on = 1'b1;
    int       model_room = 1 << 30;
    int       model_beacons = 0;
    int       model_frames = 0;
    int       model_drops = 0;
    int       ev_cycles = 0;
    int       credits_issued = 0;
    int       credits_seen = 0;
    int       seg_b;
    int       seg_c;
    int       seg_d;
    int       seg_e;
    integer   seed = 32'ha73d;

    evr_top dut0 (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .rx_word_i   (rx_word_i),
        .ev_credit_i (ev_credit_i),
        .mmr_req_i   (mmr_req_i),
        .ev_valid_o  (ev_valid_o),
        .ev_code_o   (ev_code_o),
        .mmr_rsp_o   (mmr_rsp_o)
    );

    initial begin
        rx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) rx_clk = ~rx_clk;
    end

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("[ERROR] %0t ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic step_cycle();
        @(posedge rx_clk);
        #DRIVE_DELAY;
    endtask

    // Expected behavior of one word, from the link rules
    task automatic add_word(input logic [15:0] data, input logic [1:0] k,
                            input logic wr = 1'b0, input buf_addr_t wa = '0,
                            input word_t wd = '0, input logic err = 1'b0);
        row_t  r;
        byte_t up;
        up = data[15:8];
        r = '0;
        r.word.data    = data;
        r.word.charisk = k;
        if (!k[1] && up == BEACON_CODE) begin
            model_beacons++;
        end else if (!k[1] && up != 8'h00 && model_link && model_ena) begin
            if (model_room > 0) begin
                r.exp_ev   = 1'b1;
                r.exp_code = up;
                model_room--;
            end else begin
                model_drops++;
            end
        end
        if (k[1] && up == K_COMMA) begin
            model_link = 1'b1;
        end
        r.exp_wr  = wr;
        r.wr_addr = wa;
        r.wr_data = wd;
        r.exp_err = err;
        if (wr) begin
            model_frames++;
        end
        rows.push_back(r);
    endtask

    task automatic add_frame(input buf_addr_t a, input word_t w, input logic complete);
        add_word({8'h00, K_FRAME_START}, 2'b01);
        add_word({8'h00, 2'b00, a}, 2'b00);
        add_word({8'h00, w[31:24]}, 2'b00);
        add_word({8'h00, w[23:16]}, 2'b00);
        if (complete) begin
            add_word({8'h00, w[15:8]}, 2'b00);
            add_word({8'h00, w[7:0]}, 2'b00, 1'b1, a, w);
        end else begin
            // Control byte cuts the frame short
            add_word({8'h00, K_COMMA}, 2'b01, 1'b0, a, '0, 1'b1);
        end
    endtask

    task automatic build_table();
        add_word({K_COMMA, 8'h00}, 2'b10);
        add_word({8'h11, 8'h00}, 2'b00);
        add_word({BEACON_CODE, 8'h00}, 2'b00);
        add_word({K_COMMA, 8'h00}, 2'b10);
        add_word({BEACON_CODE, 8'h00}, 2'b00);
        add_word({8'h12, 8'h00}, 2'b00);
        seg_b = rows.size();
        model_ena = 1'b1;
        add_word({K_COMMA, 8'h00}, 2'b10);
        add_word({8'h21, 8'h00}, 2'b00);
        add_frame(6'd5, 32'hDEADBEEF, 1'b1);
        add_word({8'h22, 8'h00}, 2'b00);
        add_word({BEACON_CODE, 8'h00}, 2'b00);
        add_frame(6'd12, 32'h01234567, 1'b1);
        add_word({8'h1C, 8'h00}, 2'b10);
        add_word({8'h23, 8'h00}, 2'b00);
        seg_c = rows.size();
        add_frame(6'd20, 32'hCAFEF00D, 1'b1);
        add_frame(6'd5, 32'h55AA33CC, 1'b0);
        add_frame(6'd63, 32'h0BADC0DE, 1'b1);
        add_word({8'h31, 8'h00}, 2'b00);
        add_word({8'h32, 8'h00}, 2'b00);
        seg_d = rows.size();
        // No credits come back here, so the queue overflows
        model_room = EV_CREDITS + EV_QUEUE_DEPTH;
        add_word({K_COMMA, 8'h00}, 2'b10);
        for (int i = 0; i < EV_CREDITS + EV_QUEUE_DEPTH + EXTRA_EVENTS; i++) begin
            add_word({byte_t'(8'h40 + i), 8'h00}, 2'b00);
        end
        seg_e = rows.size();
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i < last; i++) begin
            rx_word_i = rows[i].word;
            if (rows[i].exp_ev) begin
                exp_codes.push_back(rows[i].exp_code);
            end
            if (rows[i].exp_wr) begin
                exp_buf[rows[i].wr_addr]     = rows[i].wr_data;
                exp_buf_set[rows[i].wr_addr] = 1'b1;
            end
            if (rows[i].exp_err) begin
                run_err = 1'b1;
            end
            step_cycle();
        end
        rx_word_i = rx_idle;
    endtask

    task automatic host_access(input logic write, input mmr_addr_t addr, input word_t wdata,
                               output word_t rdata);
        mmr_req_i = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
        step_cycle();
        mmr_req_i = '0;
        while (!mmr_rsp_o.valid) begin
            step_cycle();
        end
        rdata = mmr_rsp_o.rdata;
    endtask

    task automatic write_reg(input mmr_addr_t addr, input word_t data);
        word_t unused;
        host_access(1'b1, addr, data, unused);
    endtask

    task automatic check_reg(input string name, input mmr_addr_t addr, input word_t exp);
        word_t act;
        host_access(1'b0, addr, '0, act);
        assert (act == exp) else report_mismatch(name, exp, act);
    endtask

    task automatic check_buf(input int a);
        check_reg($sformatf("buf[%0d]", a), mmr_addr_t'(BUF_WINDOW_BASE + 4 * a), exp_buf[a]);
    endtask

    task automatic wait_drain();
        while (exp_codes.size() != 0 || credits_issued != ev_cycles) begin
            step_cycle();
        end
    endtask

    // Consumer returns one credit per received event after a random gap
    initial begin : credit_return
        int gap;
        gap = 0;
        ev_credit_i = 1'b0;
        forever begin
            step_cycle();
            ev_credit_i = 1'b0;
            if (credits_on && credits_issued < ev_cycles) begin
                if (gap == 0) begin
                    ev_credit_i = 1'b1;
                    credits_issued++;
                    gap = $unsigned($random(seed)) % 4;
                end else begin
                    gap--;
                end
            end
        end
    end

    always @(negedge rx_clk) begin
        if (!app_rst) begin
            if (ev_valid_o) begin
                ev_cycles++;
                assert (ev_cycles <= EV_CREDITS + credits_seen)
                    else report_failure("event was output without a credit");
                assert (exp_codes.size() != 0)
                    else report_failure("event was output while none was expected");
                exp_code = exp_codes.pop_front();
                assert (ev_code_o == exp_code)
                    else report_mismatch("ev_code_o", word_t'(exp_code), word_t'(ev_code_o));
            end
            if (ev_credit_i) begin
                credits_seen++;
            end
        end
    end

    initial begin : watchdog
        wait (rows_ready);
        #((rows.size() + WATCHDOG_MARGIN) * CLK_PERIOD);
        report_failure("simulation timed out before all tests finished");
    end

    initial begin : main
        app_rst   = 1'b1;
        rx_word_i = '0;
        mmr_req_i = '0;
        rx_idle   = '0;
        build_table();
        rows_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge rx_clk);
        #DRIVE_DELAY;
        app_rst = 1'b0;
        step_cycle();

        // No comma yet, so the enable bit must not stick
        check_reg("SR", SR_ADDR, 32'h0);
        write_reg(CR_ADDR, 32'h1);
        check_reg("CR", CR_ADDR, 32'h0);

        rx_idle = '{data: {K_COMMA, 8'h00}, charisk: 2'b10};
        apply_rows(0, seg_b);
        check_reg("SR", SR_ADDR, 32'h1);
        write_reg(CR_ADDR, 32'h1);
        check_reg("CR", CR_ADDR, 32'h1);
        check_reg("unmapped 0x014", 9'h014, 32'h0);

        apply_rows(seg_b, seg_c);
        fork
            apply_rows(seg_c, seg_d);
            begin
                check_buf(5);
                check_buf(12);
                check_buf(5);
                check_buf(12);
            end
        join
        wait_drain();
        check_reg("SR", SR_ADDR, word_t'({run_err, 1'b1}));

        credits_on = 1'b0;
        repeat (2) step_cycle();
        apply_rows(seg_d, seg_e);
        repeat (4) step_cycle();
        check_reg("EV_DROP", EV_DROP_ADDR, word_t'(model_drops));
        credits_on = 1'b1;
        wait_drain();

        // Commas stop, link times out
        rx_idle   = '0;
        rx_word_i = rx_idle;
        repeat (LINK_TIMEOUT + 4) step_cycle();
        check_reg("SR", SR_ADDR, word_t'({run_err, 1'b0}));
        check_reg("CR", CR_ADDR, 32'h0);
        check_reg("BEACON_CNT", BEACON_CNT_ADDR, word_t'(model_beacons));
        check_reg("FRAME_CNT", FRAME_CNT_ADDR, word_t'(model_frames));
        for (int a = 0; a < BUF_DEPTH; a++) begin
            if (exp_buf_set[a]) begin
                check_buf(a);
            end
        end
        check_reg("unmapped 0x0FC", 9'h0FC, 32'h0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/evr_buffer_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module evr_buffer_arbiter import evr_pkg::*; (
    input  logic     rx_clk,
    input  logic     app_rst,
    input  buf_req_t parser_req_i,
    input  buf_req_t host_req_i,
    output logic     parser_grant_o,
    output logic     host_grant_o,
    output buf_req_t mem_req_o
);
    // Host read in flight, its data is on the memory output this cycle
    logic host_rd_q;

    assign parser_grant_o = parser_req_i.req;
    assign host_grant_o   = host_req_i.req && !parser_req_i.req && !host_rd_q;

    always_comb begin
        if (parser_grant_o) begin
            mem_req_o = parser_req_i;
        end else begin
            mem_req_o     = host_req_i;
            mem_req_o.req = host_grant_o;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= host_grant_o && !host_req_i.write;
        end
    end

endmodule

`default_nettype wire

// File: source/evr_event_queue.sv
`timescale 1ns/1ns
`default_nettype none

module evr_event_queue import evr_pkg::*; (
    input  logic  rx_clk,
    input  logic  app_rst,
    input  logic  ev_push_i,
    input  byte_t ev_code_i,
    input  logic  ev_credit_i,
    output logic  ev_valid_o,
    output byte_t ev_code_o,
    output cnt_t  drop_cnt_o
);
    byte_t    mem [EV_QUEUE_DEPTH];
    ev_ptr_t  wr_ptr;
    ev_ptr_t  rd_ptr;
    ev_fill_t fill;
    credit_t  credits;
    logic     full;
    logic     push_ok;
    logic     pop;

    assign full    = (fill == ev_fill_t'(EV_QUEUE_DEPTH));
    assign push_ok = ev_push_i && !full;

    // One credit is spent per delivered entry
    assign pop        = (fill != '0) && (credits != '0);
    assign ev_valid_o = pop;
    assign ev_code_o  = mem[rd_ptr];

    always_ff @(posedge rx_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= ev_code_i;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            credits    <= credit_t'(EV_CREDITS);
            drop_cnt_o <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill    <= fill + ev_fill_t'(push_ok) - ev_fill_t'(pop);
            credits <= credits + credit_t'(ev_credit_i) - credit_t'(pop);

            if (ev_push_i && full) begin
                drop_cnt_o <= drop_cnt_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/evr_frame_parser.sv
`timescale 1ns/1ns
`default_nettype none

module evr_frame_parser import evr_pkg::*; (
    input  logic     rx_clk,
    input  logic     app_rst,
    input  logic     data_valid_i,
    input  byte_t    data_byte_i,
    input  logic     data_k_i,
    input  logic     grant_i,
    output buf_req_t buf_req_o,
    output cnt_t     frame_cnt_o,
    output logic     parser_err_o
);
    parser_state_t state;
    buf_addr_t     frame_addr;
    logic [1:0]    byte_idx;
    logic [23:0]   shift_q;
    logic          wr_req;
    buf_addr_t     wr_addr;
    word_t         wr_data;
    logic          start_seen;

    assign start_seen = data_k_i && (data_byte_i == K_FRAME_START);

    assign buf_req_o = '{req: wr_req, write: 1'b1, addr: wr_addr, wdata: wr_data};

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            state        <= IDLE;
            byte_idx     <= '0;
            wr_req       <= 1'b0;
            frame_cnt_o  <= '0;
            parser_err_o <= 1'b0;
        end else begin
            if (wr_req && grant_i) begin
                wr_req      <= 1'b0;
                frame_cnt_o <= frame_cnt_o + 1'b1;
            end

            if (data_valid_i) begin
                if (state != IDLE && data_k_i) begin
                    // Control byte inside a frame, a start marker reopens it
                    parser_err_o <= 1'b1;
                    state        <= start_seen ? ADDR : IDLE;
                end else begin
                    case (state)
                        IDLE: begin
                            if (start_seen) begin
                                state <= ADDR;
                            end
                        end
                        ADDR: begin
                            frame_addr <= buf_addr_t'(data_byte_i);
                            byte_idx   <= '0;
                            state      <= DATA;
                        end
                        DATA: begin
                            shift_q  <= {shift_q[15:0], data_byte_i};
                            byte_idx <= byte_idx + 1'b1;
                            if (byte_idx == 2'd3) begin
                                wr_req  <= 1'b1;
                                wr_addr <= frame_addr;
                                wr_data <= {shift_q, data_byte_i};
                                state   <= IDLE;
                            end
                        end
                        default: state <= IDLE;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/evr_mmr.sv
`timescale 1ns/1ns
`default_nettype none

module evr_mmr import evr_pkg::*; (
    input  logic     rx_clk,
    input  logic     app_rst,
    input  mmr_req_t mmr_req_i,
    input  logic     link_up_i,
    input  logic     parser_err_i,
    input  cnt_t     beacon_cnt_i,
    input  cnt_t     frame_cnt_i,
    input  cnt_t     drop_cnt_i,
    input  logic     host_grant_i,
    input  word_t    buf_rdata_i,
    output mmr_rsp_t mmr_rsp_o,
    output logic     ev_ena_o,
    output buf_req_t host_buf_req_o
);
    logic      rsp_valid_q;
    word_t     rsp_rdata_q;
    logic      buf_rd_req;
    logic      buf_rd_wait;
    buf_addr_t buf_rd_addr;
    logic      in_window;
    word_t     reg_rdata;

    assign in_window = (mmr_req_i.addr >= BUF_WINDOW_BASE);

    assign host_buf_req_o = '{req: buf_rd_req, write: 1'b0, addr: buf_rd_addr, wdata: '0};

    // Buffer data goes straight out in the cycle after the grant
    assign mmr_rsp_o.valid = rsp_valid_q || buf_rd_wait;
    assign mmr_rsp_o.rdata = buf_rd_wait ? buf_rdata_i : rsp_rdata_q;

    always_comb begin
        case (mmr_req_i.addr)
            SR_ADDR:         reg_rdata = word_t'({parser_err_i, link_up_i});
            CR_ADDR:         reg_rdata = word_t'(ev_ena_o);
            BEACON_CNT_ADDR: reg_rdata = beacon_cnt_i;
            FRAME_CNT_ADDR:  reg_rdata = frame_cnt_i;
            EV_DROP_ADDR:    reg_rdata = drop_cnt_i;
            default:         reg_rdata = '0;
        endcase
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            rsp_valid_q <= 1'b0;
            buf_rd_req  <= 1'b0;
            buf_rd_wait <= 1'b0;
            ev_ena_o    <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            buf_rd_wait <= buf_rd_req && host_grant_i;
            if (buf_rd_req && host_grant_i) begin
                buf_rd_req <= 1'b0;
            end

            if (mmr_req_i.valid) begin
                if (mmr_req_i.write) begin
                    rsp_valid_q <= 1'b1;
                    rsp_rdata_q <= '0;
                    if (mmr_req_i.addr == CR_ADDR) begin
                        ev_ena_o <= mmr_req_i.wdata[0];
                    end
                end else if (in_window) begin
                    buf_rd_req  <= 1'b1;
                    buf_rd_addr <= mmr_req_i.addr[7:2];
                end else begin
                    rsp_valid_q <= 1'b1;
                    rsp_rdata_q <= reg_rdata;
                end
            end

            // Events stay off while the link is down
            if (!link_up_i) begin
                ev_ena_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/evr_pkg.sv
`default_nettype none

package evr_pkg;

    // Sizes
    localparam int BUF_DEPTH      = 64;
    localparam int EV_QUEUE_DEPTH = 16;
    localparam int EV_CREDITS     = 4;
    localparam int LINK_TIMEOUT   = 64;
    localparam int EV_PTR_W       = $clog2(EV_QUEUE_DEPTH);
    localparam int LINK_CNT_W     = $clog2(LINK_TIMEOUT) + 1;
    localparam int CREDIT_W       = 8;

    typedef logic [7:0]                   byte_t;
    typedef logic [31:0]                  word_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;
    typedef logic [8:0]                   mmr_addr_t;
    typedef logic [31:0]                  cnt_t;
    typedef logic [EV_PTR_W-1:0]          ev_ptr_t;
    typedef logic [EV_PTR_W:0]            ev_fill_t;
    typedef logic [CREDIT_W-1:0]          credit_t;
    typedef logic [LINK_CNT_W-1:0]        link_cnt_t;

    // Link codes
    localparam byte_t K_COMMA       = 8'hBC;
    localparam byte_t BEACON_CODE   = 8'h7E;
    localparam byte_t K_FRAME_START = 8'h5C;

    // Register map
    localparam mmr_addr_t SR_ADDR         = 9'h000;
    localparam mmr_addr_t CR_ADDR         = 9'h004;
    localparam mmr_addr_t BEACON_CNT_ADDR = 9'h008;
    localparam mmr_addr_t FRAME_CNT_ADDR  = 9'h00C;
    localparam mmr_addr_t EV_DROP_ADDR    = 9'h010;
    localparam mmr_addr_t BUF_WINDOW_BASE = 9'h100;

    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  charisk;
    } rx_word_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        mmr_addr_t addr;
        word_t     wdata;
    } mmr_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mmr_rsp_t;

    typedef struct packed {
        logic      req;
        logic      write;
        buf_addr_t addr;
        word_t     wdata;
    } buf_req_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } parser_state_t;

endpackage

`default_nettype wire

// File: source/evr_rx_demux.sv
`timescale 1ns/1ns
`default_nettype none

module evr_rx_demux import evr_pkg::*; (
    input  logic     rx_clk,
    input  logic     app_rst,
    input  rx_word_t rx_word_i,
    input  logic     ev_ena_i,
    output logic     ev_push_o,
    output byte_t    ev_code_o,
    output logic     data_valid_o,
    output byte_t    data_byte_o,
    output logic     data_k_o,
    output logic     link_up_o,
    output cnt_t     beacon_cnt_o
);
    byte_t     upper;
    logic      upper_k;
    logic      is_comma;
    logic      is_beacon;
    logic      is_event;
    link_cnt_t link_cnt;

    assign upper   = rx_word_i.data[15:8];
    assign upper_k = rx_word_i.charisk[1];

    assign is_comma  = upper_k && (upper == K_COMMA);
    assign is_beacon = !upper_k && (upper == BEACON_CODE);
    assign is_event  = !upper_k && (upper != 8'h00) && (upper != BEACON_CODE);

    // Saturates at the timeout, which also holds the link down after reset
    assign link_up_o = (link_cnt != link_cnt_t'(LINK_TIMEOUT));

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            link_cnt     <= link_cnt_t'(LINK_TIMEOUT);
            beacon_cnt_o <= '0;
            ev_push_o    <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            if (is_comma) begin
                link_cnt <= '0;
            end else if (link_up_o) begin
                link_cnt <= link_cnt + 1'b1;
            end

            if (is_beacon) begin
                beacon_cnt_o <= beacon_cnt_o + 1'b1;
            end

            ev_push_o    <= is_event && link_up_o && ev_ena_i;
            ev_code_o    <= upper;
            data_valid_o <= 1'b1;
            data_byte_o  <= rx_word_i.data[7:0];
            data_k_o     <= rx_word_i.charisk[0];
        end
    end

endmodule

`default_nettype wire

// File: source/evr_shared_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module evr_shared_buffer import evr_pkg::*; (
    input  logic     rx_clk,
    input  buf_req_t mem_req_i,
    output word_t    rdata_o
);
    word_t mem [BUF_DEPTH];

    always_ff @(posedge rx_clk) begin
        if (mem_req_i.req) begin
            if (mem_req_i.write) begin
                mem[mem_req_i.addr] <= mem_req_i.wdata;
            end else begin
                rdata_o <= mem[mem_req_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/evr_top.sv
`timescale 1ns/1ns
`default_nettype none

module evr_top import evr_pkg::*; (
    input  logic     rx_clk,
    input  logic     app_rst,
    input  rx_word_t rx_word_i,
    input  logic     ev_credit_i,
    input  mmr_req_t mmr_req_i,
    output logic     ev_valid_o,
    output byte_t    ev_code_o,
    output mmr_rsp_t mmr_rsp_o
);
    logic     ev_push;
    byte_t    ev_code;
    logic     data_valid;
    byte_t    data_byte;
    logic     data_k;
    logic     link_up;
    logic     ev_ena;
    cnt_t     beacon_cnt;
    cnt_t     frame_cnt;
    cnt_t     drop_cnt;
    logic     parser_err;
    buf_req_t parser_req;
    buf_req_t host_req;
    buf_req_t mem_req;
    logic     parser_grant;
    logic     host_grant;
    word_t    buf_rdata;

    evr_rx_demux rx_demux0 (
        .rx_clk       (rx_clk),
        .app_rst      (app_rst),
        .rx_word_i    (rx_word_i),
        .ev_ena_i     (ev_ena),
        .ev_push_o    (ev_push),
        .ev_code_o    (ev_code),
        .data_valid_o (data_valid),
        .data_byte_o  (data_byte),
        .data_k_o     (data_k),
        .link_up_o    (link_up),
        .beacon_cnt_o (beacon_cnt)
    );

    evr_event_queue event_queue0 (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .ev_push_i   (ev_push),
        .ev_code_i   (ev_code),
        .ev_credit_i (ev_credit_i),
        .ev_valid_o  (ev_valid_o),
        .ev_code_o   (ev_code_o),
        .drop_cnt_o  (drop_cnt)
    );

    evr_frame_parser frame_parser0 (
        .rx_clk       (rx_clk),
        .app_rst      (app_rst),
        .data_valid_i (data_valid),
        .data_byte_i  (data_byte),
        .data_k_i     (data_k),
        .grant_i      (parser_grant),
        .buf_req_o    (parser_req),
        .frame_cnt_o  (frame_cnt),
        .parser_err_o (parser_err)
    );

    evr_buffer_arbiter buffer_arbiter0 (
        .rx_clk         (rx_clk),
        .app_rst        (app_rst),
        .parser_req_i   (parser_req),
        .host_req_i     (host_req),
        .parser_grant_o (parser_grant),
        .host_grant_o   (host_grant),
        .mem_req_o      (mem_req)
    );

    evr_shared_buffer shared_buffer0 (
        .rx_clk    (rx_clk),
        .mem_req_i (mem_req),
        .rdata_o   (buf_rdata)
    );

    evr_mmr mmr0 (
        .rx_clk         (rx_clk),
        .app_rst        (app_rst),
        .mmr_req_i      (mmr_req_i),
        .link_up_i      (link_up),
        .parser_err_i   (parser_err),
        .beacon_cnt_i   (beacon_cnt),
        .frame_cnt_i    (frame_cnt),
        .drop_cnt_i     (drop_cnt),
        .host_grant_i   (host_grant),
        .buf_rdata_i    (buf_rdata),
        .mmr_rsp_o      (mmr_rsp_o),
        .ev_ena_o       (ev_ena),
        .host_buf_req_o (host_req)
    );

endmodule

`default_nettype wire

// File: src.f
source/evr_pkg.sv
source/evr_rx_demux.sv
source/evr_event_queue.sv
source/evr_frame_parser.sv
source/evr_buffer_arbiter.sv
source/evr_shared_buffer.sv
source/evr_mmr.sv
source/evr_top.sv
sim/evr_tb.sv
